// ==== build.f ====
+incdir+logic
logic/channel_pkg.sv
logic/event_if.sv
logic/sar_converter.sv
logic/csa_reset_timer.sv
logic/channel_sequencer.sv
logic/local_fifo.sv
logic/channel_top.sv
verif/channel_tb.sv

// ==== logic/channel_cfg.svh ====
////////////////////
// channel widths, FIFO depth and DAC reset value
// include wherever the pixel channel sizes are needed
////////////////////

`ifndef CHANNEL_CFG_SVH
`define CHANNEL_CFG_SVH

// ADC code and DAC word
`define CHANNEL_ADC_BITS 8

// one stored event
`define CHANNEL_EVENT_BITS 56

// local derandomizing FIFO, power of two
`define CHANNEL_FIFO_DEPTH 8

// timestamp bits kept in the event
`define CHANNEL_TS_BITS 28

// mid-scale DAC word, used at reset and during readout
`define CHANNEL_DAC_MIDSCALE 8'h80

`endif

// ==== logic/channel_pkg.sv ====
////////////////////
// types shared by the channel blocks and the testbench
////////////////////

`include "channel_cfg.svh"

package channel_pkg;

    typedef enum logic [2:0] {
        IDLE            = 3'd0,
        SAMPLE          = 3'd1,
        RESET_CSA       = 3'd2,
        CONVERT         = 3'd3,
        REQUEST_READOUT = 3'd4,
        TRANSFER        = 3'd5
    } seq_state_t;

    typedef enum logic [1:0] {
        NATURAL  = 2'd0,
        EXTERNAL = 2'd1,
        CROSS    = 2'd2
    } trigger_type_t;

    localparam logic [1:0] PACKET_TYPE_DATA = 2'b01;

    // event layout, msb first
    typedef struct packed {
        logic                         local_fifo_half;
        logic                         local_fifo_full;
        trigger_type_t                trigger_type;
        logic [`CHANNEL_ADC_BITS-1:0] adc_code;
        logic [`CHANNEL_TS_BITS-1:0]  timestamp;
        logic [5:0]                   channel_id;
        logic [7:0]                   chip_id;
        logic [1:0]                   packet_type;
    } channel_event_t;

endpackage

// ==== logic/channel_sequencer.sv ====
////////////////////
// channel FSM: trigger qualification, sample hold, burst control
// and event assembly towards the local FIFO
////////////////////

`timescale 1ns/1ns

`include "channel_cfg.svh"

module channel_sequencer (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         channel_enabled,
    input  logic                         hit,
    input  logic                         channel_mask,
    input  logic                         external_trigger,
    input  logic                         external_trigger_mask,
    input  logic                         cross_trigger,
    input  logic                         cross_trigger_mask,
    input  logic [7:0]                   chip_id,
    input  logic [5:0]                   channel_id,
    input  logic [31:0]                  timestamp,
    input  logic [7:0]                   adc_burst,          // conversions per trigger
    input  logic [7:0]                   adc_hold_delay,     // extra sample cycles
    input  logic [`CHANNEL_ADC_BITS-1:0] digital_threshold,
    input  logic                         sar_done,
    input  logic [`CHANNEL_ADC_BITS-1:0] adc_code,
    output logic                         triggered_natural,
    output logic                         sample,
    output logic                         sar_start,
    output logic                         reset_request,
    output logic                         readout_mode,
    event_if.writer                      ev
);

    import channel_pkg::*;

    seq_state_t                  state;
    seq_state_t                  next_state;
    logic                        triggered_external;
    logic                        triggered_cross;
    logic                        triggered;
    trigger_type_t               trig_type;
    trigger_type_t               trig_type_q;
    logic [`CHANNEL_TS_BITS-1:0] ts_q;
    logic [7:0]                  sample_cnt;
    logic [7:0]                  burst_cnt;   // conversions finished
    logic                        last_conv;
    channel_event_t              event_d;

    ////////////////////
    // trigger qualification

    always_comb begin
        triggered_natural  = hit & ~channel_mask;
        triggered_external = external_trigger & ~external_trigger_mask;
        triggered_cross    = cross_trigger & ~cross_trigger_mask;
        triggered          = triggered_natural | triggered_external | triggered_cross;
        if (triggered_natural)
            trig_type = NATURAL;
        else if (triggered_external)
            trig_type = EXTERNAL;
        else
            trig_type = CROSS;
    end

    // burst of 0 or 1 gives a single conversion
    assign last_conv = ({1'b0, burst_cnt} + 9'd1) >= {1'b0, adc_burst};

    ////////////////////
    // state machine

    always_comb begin
        next_state = state;
        case (state)
            IDLE:            if (channel_enabled && triggered) next_state = SAMPLE;
            SAMPLE:          if (sample_cnt == adc_hold_delay) next_state = RESET_CSA;
            RESET_CSA:       next_state = CONVERT;
            CONVERT:         if (sar_done) next_state = REQUEST_READOUT;
            REQUEST_READOUT: if (!ev.full) next_state = TRANSFER;  // wait for space
            TRANSFER:        next_state = last_conv ? IDLE : SAMPLE;
            default:         next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= IDLE;
            sample_cnt <= 8'd0;
            burst_cnt  <= 8'd0;
        end else begin
            state      <= next_state;
            sample_cnt <= (state == SAMPLE) ? sample_cnt + 8'd1 : 8'd0;
            if (state == IDLE)
                burst_cnt <= 8'd0;
            else if (state == TRANSFER)
                burst_cnt <= burst_cnt + 8'd1;
        end
    end

    // trigger type and time are frozen once the FSM leaves IDLE
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            trig_type_q <= trig_type;
            ts_q        <= timestamp[`CHANNEL_TS_BITS-1:0];
        end
    end

    ////////////////////
    // outputs and event

    assign sample        = (state != RESET_CSA) && (state != CONVERT);  // hold while converting
    assign sar_start     = (state == RESET_CSA);
    assign reset_request = (state == RESET_CSA) && last_conv;
    assign readout_mode  = (state == REQUEST_READOUT) || (state == TRANSFER);

    always_comb begin
        event_d.local_fifo_half = ev.half;
        event_d.local_fifo_full = ev.full;
        event_d.trigger_type    = trig_type_q;
        event_d.adc_code        = adc_code;
        event_d.timestamp       = ts_q;
        event_d.channel_id      = channel_id;
        event_d.chip_id         = chip_id;
        event_d.packet_type     = PACKET_TYPE_DATA;
    end

    assign ev.event_word = event_d;
    assign ev.write_n    = !((state == TRANSFER) && (adc_code >= digital_threshold));

endmodule

// ==== logic/channel_top.sv ====
////////////////////
// one pixel readout channel, plain ports towards the chip
////////////////////

`timescale 1ns/1ns

`include "channel_cfg.svh"

module channel_top (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         channel_enabled,
    input  logic                         hit,                // discriminator
    input  logic                         comp,               // SAR comparator
    input  logic                         external_trigger,
    input  logic                         cross_trigger,
    input  logic                         channel_mask,
    input  logic                         external_trigger_mask,
    input  logic                         cross_trigger_mask,
    input  logic [7:0]                   chip_id,
    input  logic [5:0]                   channel_id,
    input  logic [31:0]                  timestamp,
    input  logic [7:0]                   adc_burst,
    input  logic [7:0]                   adc_hold_delay,
    input  logic [7:0]                   reset_length,
    input  logic [`CHANNEL_ADC_BITS-1:0] digital_threshold,
    input  logic                         read_local_fifo_n,
    output channel_pkg::channel_event_t  channel_event,      // FIFO head
    output logic                         fifo_empty,
    output logic                         triggered_natural,
    output logic                         csa_reset,
    output logic                         sample,
    output logic [`CHANNEL_ADC_BITS-1:0] dac_word
);

    logic                         sar_start;
    logic                         sar_done;
    logic [`CHANNEL_ADC_BITS-1:0] adc_code;
    logic                         reset_request;
    logic                         readout_mode;

    event_if ev_bus ();

    channel_sequencer channel_sequencer_inst (
        .clk                   (clk),
        .reset_n               (reset_n),
        .channel_enabled       (channel_enabled),
        .hit                   (hit),
        .channel_mask          (channel_mask),
        .external_trigger      (external_trigger),
        .external_trigger_mask (external_trigger_mask),
        .cross_trigger         (cross_trigger),
        .cross_trigger_mask    (cross_trigger_mask),
        .chip_id               (chip_id),
        .channel_id            (channel_id),
        .timestamp             (timestamp),
        .adc_burst             (adc_burst),
        .adc_hold_delay        (adc_hold_delay),
        .digital_threshold     (digital_threshold),
        .sar_done              (sar_done),
        .adc_code              (adc_code),
        .triggered_natural     (triggered_natural),
        .sample                (sample),
        .sar_start             (sar_start),
        .reset_request         (reset_request),
        .readout_mode          (readout_mode),
        .ev                    (ev_bus)
    );

    sar_converter sar_converter_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .start        (sar_start),
        .comp         (comp),
        .readout_mode (readout_mode),
        .done         (sar_done),
        .adc_code     (adc_code),
        .dac_word     (dac_word)
    );

    csa_reset_timer csa_reset_timer_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .reset_request (reset_request),
        .reset_length  (reset_length),
        .csa_reset     (csa_reset)
    );

    local_fifo #(
        .DEPTH (`CHANNEL_FIFO_DEPTH)
    ) local_fifo_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .read_n  (read_local_fifo_n),
        .ev      (ev_bus),
        .head    (channel_event),
        .empty   (fifo_empty)
    );

endmodule

// ==== logic/csa_reset_timer.sv ====
////////////////////
// holds csa_reset for reset_length cycles after each request
////////////////////

`timescale 1ns/1ns

module csa_reset_timer (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       reset_request,  // one-cycle pulse
    input  logic [7:0] reset_length,   // 0 behaves as 1
    output logic       csa_reset
);

    logic [7:0] remaining;  // cycles left after the current one

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            csa_reset <= 1'b0;
            remaining <= 8'd0;
        end else if (reset_request) begin
            csa_reset <= 1'b1;
            if (reset_length == 8'd0)
                remaining <= 8'd0;
            else
                remaining <= reset_length - 8'd1;
        end else if (csa_reset) begin
            if (remaining == 8'd0)
                csa_reset <= 1'b0;
            else
                remaining <= remaining - 8'd1;
        end
    end

endmodule

// ==== logic/event_if.sv ====
////////////////////
// event path from the sequencer into the local FIFO
////////////////////

`timescale 1ns/1ns

interface event_if;

    import channel_pkg::*;

    channel_event_t event_word;  // assembled event
    logic           write_n;     // one-cycle low write strobe
    logic           full;        // occupancy equals depth
    logic           half;        // occupancy at least half depth

    modport writer (
        output event_word,
        output write_n,
        input  full,
        input  half
    );

    modport store (
        input  event_word,
        input  write_n,
        output full,
        output half
    );

endinterface

// ==== logic/local_fifo.sv ====
////////////////////
// derandomizing first-word-fall-through FIFO for channel events
////////////////////

`timescale 1ns/1ns

`include "channel_cfg.svh"

module local_fifo #(
    parameter int DEPTH = `CHANNEL_FIFO_DEPTH  // power of two
) (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        read_n,  // low pops the head
    event_if.store                      ev,
    output channel_pkg::channel_event_t head,
    output logic                        empty
);

    import channel_pkg::*;

    localparam int PTR_BITS = $clog2(DEPTH);
    localparam int CNT_BITS = PTR_BITS + 1;
    localparam logic [CNT_BITS-1:0] FULL_COUNT = CNT_BITS'(DEPTH);
    localparam logic [CNT_BITS-1:0] HALF_COUNT = CNT_BITS'(DEPTH / 2);

    channel_event_t      mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                do_write;
    logic                do_read;

    assign do_write = !ev.write_n;            // writer checks full
    assign do_read  = !read_n && !empty;       // empty reads ignored

    always_ff @(posedge clk) begin
        if (do_write)
            mem[wr_ptr] <= ev.event_word;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_read)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head    = mem[rd_ptr];
    assign empty   = (count == '0);
    assign ev.full = (count == FULL_COUNT);
    assign ev.half = (count >= HALF_COUNT);

endmodule

// ==== logic/sar_converter.sv ====
////////////////////
// successive-approximation register driven by the external comparator
// start launches a fixed 8-cycle binary search, dac_word feeds the DAC
////////////////////

`timescale 1ns/1ns

`include "channel_cfg.svh"

module sar_converter (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         start,         // one-cycle pulse
    input  logic                         comp,          // high keeps trial bit
    input  logic                         readout_mode,  // park the DAC
    output logic                         done,          // last trial cycle
    output logic [`CHANNEL_ADC_BITS-1:0] adc_code,
    output logic [`CHANNEL_ADC_BITS-1:0] dac_word
);

    localparam logic [`CHANNEL_ADC_BITS-1:0] MSB_MASK = `CHANNEL_DAC_MIDSCALE;

    logic [`CHANNEL_ADC_BITS-1:0] mask_q;  // bit under trial
    logic [`CHANNEL_ADC_BITS-1:0] code_q;  // bits decided so far
    logic                         busy;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mask_q <= MSB_MASK;
            code_q <= '0;
            busy   <= 1'b0;
        end else if (start) begin
            mask_q <= MSB_MASK;
            code_q <= '0;
            busy   <= 1'b1;
        end else if (busy) begin
            if (comp)
                code_q <= code_q | mask_q;
            mask_q <= mask_q >> 1;
            if (mask_q[0])
                busy <= 1'b0;  // lsb decided this cycle
        end
    end

    assign done = busy & mask_q[0];

    // final code is already valid in the done cycle
    assign adc_code = busy ? (code_q | (mask_q & {`CHANNEL_ADC_BITS{comp}})) : code_q;

    assign dac_word = readout_mode ? MSB_MASK : (code_q | mask_q);

endmodule

// ==== run.sh ====
#!/bin/sh
# compile the channel testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module channel_tb -o channel_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/channel_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// ==== verif/channel_tb.sv ====
////////////////////
// testbench for the pixel readout channel, random triggers against a model
// run through build.f with channel_tb as the top module
////////////////////

`timescale 1ns/1ns

`include "channel_cfg.svh"

module channel_tb;

    import channel_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int DEPTH           = `CHANNEL_FIFO_DEPTH;
    localparam int MAX_HOLD        = 7;
    localparam int MAX_BURST       = 4;
    localparam int NUM_TESTS       = 41;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (8 + MAX_HOLD + MAX_BURST * 40);

    logic                         clk;
    logic                         reset_n;
    logic                         channel_enabled;
    logic                         hit;
    logic                         comp;
    logic                         external_trigger;
    logic                         cross_trigger;
    logic                         channel_mask;
    logic                         external_trigger_mask;
    logic                         cross_trigger_mask;
    logic [7:0]                   chip_id;
    logic [5:0]                   channel_id;
    logic [31:0]                  timestamp;
    logic [7:0]                   adc_burst;
    logic [7:0]                   adc_hold_delay;
    logic [7:0]                   reset_length;
    logic [`CHANNEL_ADC_BITS-1:0] digital_threshold;
    logic                         read_local_fifo_n;
    channel_event_t               channel_event;
    logic                         fifo_empty;
    logic                         triggered_natural;
    logic                         csa_reset;
    logic                         sample;
    logic [`CHANNEL_ADC_BITS-1:0] dac_word;

    logic [7:0]     analog_code;     // input level seen by the comparator
    channel_event_t exp_q[$];        // every event the DUT should store
    int             exp_rd       = 0;
    int             seed;
    int             error_count  = 0;
    int             check_count  = 0;
    int             test_count   = 0;
    int             test_errors  = 0;
    logic           reads_held   = 1'b0;
    int             pops_granted = 0;  // single pops allowed while held
    int             conv_count   = 0;  // sample rising edges
    logic           sample_prev  = 1'b1;
    int             run_len      = 0;
    int             last_run     = 0;
    int             runs_seen    = 0;

    // comparator trips while the trial code is not above the input level
    assign comp = (dac_word <= analog_code);

    channel_top channel_top_inst (
        .clk                   (clk),
        .reset_n               (reset_n),
        .channel_enabled       (channel_enabled),
        .hit                   (hit),
        .comp                  (comp),
        .external_trigger      (external_trigger),
        .cross_trigger         (cross_trigger),
        .channel_mask          (channel_mask),
        .external_trigger_mask (external_trigger_mask),
        .cross_trigger_mask    (cross_trigger_mask),
        .chip_id               (chip_id),
        .channel_id            (channel_id),
        .timestamp             (timestamp),
        .adc_burst             (adc_burst),
        .adc_hold_delay        (adc_hold_delay),
        .reset_length          (reset_length),
        .digital_threshold     (digital_threshold),
        .read_local_fifo_n     (read_local_fifo_n),
        .channel_event         (channel_event),
        .fifo_empty            (fifo_empty),
        .triggered_natural     (triggered_natural),
        .csa_reset             (csa_reset),
        .sample                (sample),
        .dac_word              (dac_word)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the DUT stopped making progress");
        $display("test failed");
        $finish;
    end

    ////////////////////
    // helpers

    function automatic logic [7:0] draw(input int limit);
        return 8'($unsigned($random(seed)) % limit);
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            test_errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        test_errors++;
        $display("error: %s", msg);
    endtask

    task automatic finish_test(input string name);
        test_count++;
        $display("test %0d %s: %s", test_count, name, (test_errors == 0) ? "ok" : "errors");
        test_errors = 0;
    endtask

    task automatic push_expected(input trigger_type_t kind, input logic [7:0] code,
                                 input logic [31:0] ts, input logic [7:0] chip,
                                 input logic [5:0] chan, input int occupancy);
        channel_event_t expected;
        expected.local_fifo_half = (occupancy >= DEPTH / 2);  // occupancy before write
        expected.local_fifo_full = (occupancy >= DEPTH);
        expected.trigger_type    = kind;
        expected.adc_code        = code;
        expected.timestamp       = ts[`CHANNEL_TS_BITS-1:0];
        expected.channel_id      = chan;
        expected.chip_id         = chip;
        expected.packet_type     = 2'b01;                     // data packet
        exp_q.push_back(expected);
    endtask

    // one clock edge: reader, csa_reset run length and conversion count
    task automatic step();
        @(posedge clk);
        if (!read_local_fifo_n) begin
            read_local_fifo_n <= 1'b1;  // pop lands on this edge
        end else if (!fifo_empty && (!reads_held || pops_granted > 0)) begin
            if (exp_rd < exp_q.size()) begin
                check_value("channel_event", 64'(channel_event), 64'(exp_q[exp_rd]));
                exp_rd++;
            end else begin
                report_error("the FIFO holds an event that no trigger should have made");
            end
            if (reads_held)
                pops_granted--;
            read_local_fifo_n <= 1'b0;
        end
        if (csa_reset) begin
            run_len++;
        end else if (run_len != 0) begin
            runs_seen++;
            last_run = run_len;
            run_len  = 0;
        end
        if (sample && !sample_prev)
            conv_count++;               // back from conversion
        sample_prev = sample;
    endtask

    // one trigger with the configuration already driven, then wait for its events
    task automatic fire(input logic en, input logic [2:0] trig, input logic [2:0] masks,
                        input logic [7:0] code, input string name);
        logic [2:0]    qual_bits;
        logic          qualified;
        trigger_type_t kind;
        int            n_conv;
        int            pending;
        int            occupancy;
        logic [31:0]   ts;
        logic [7:0]    chip;
        logic [5:0]    chan;
        conv_count = 0;
        runs_seen  = 0;
        ts         = $random(seed);
        chip       = draw(256);
        chan       = 6'(draw(64));
        step();
        channel_enabled       <= en;
        hit                   <= trig[0];
        external_trigger      <= trig[1];
        cross_trigger         <= trig[2];
        channel_mask          <= masks[0];
        external_trigger_mask <= masks[1];
        cross_trigger_mask    <= masks[2];
        chip_id               <= chip;
        channel_id            <= chan;
        timestamp             <= ts;
        analog_code           <= code;
        qual_bits = trig & ~masks;
        qualified = en && (qual_bits != 3'b000);
        kind      = qual_bits[0] ? NATURAL : (qual_bits[1] ? EXTERNAL : CROSS);
        n_conv    = (adc_burst <= 8'd1) ? 1 : int'(adc_burst);
        pending   = exp_q.size() - exp_rd;
        // a full FIFO frees one slot before the stalled event goes in
        occupancy = reads_held ? ((pending > DEPTH - 1) ? DEPTH - 1 : pending) : 0;
        if (qualified && code >= digital_threshold) begin
            for (int k = 0; k < n_conv; k++)
                push_expected(kind, code, ts, chip, chan, occupancy);
        end
        step();
        check_value("triggered_natural", 64'(triggered_natural), 64'(trig[0] & ~masks[0]));
        hit              <= 1'b0;
        external_trigger <= 1'b0;
        cross_trigger    <= 1'b0;
        timestamp        <= $random(seed);  // must not reach the event
        if (qualified) begin
            while (conv_count < n_conv)
                step();
            repeat (2) step();
            while (csa_reset)
                step();
            if (runs_seen != 1)
                report_error($sformatf("csa_reset had %0d high runs in one burst", runs_seen));
            else
                check_value("csa_reset run", 64'(last_run),
                            64'((reset_length == 8'd0) ? 8'd1 : reset_length));
        end else begin
            repeat (adc_hold_delay + 14) step();
            if (conv_count != 0 || runs_seen != 0)
                report_error("a trigger that should be ignored started a conversion");
        end
        if (!reads_held) begin
            repeat (3) step();
            while (exp_rd < exp_q.size())
                step();
        end
        finish_test(name);
    endtask

    ////////////////////
    // test sequence

    initial begin
        int         i;
        int         rd_before;
        logic [7:0] thr;
        logic [7:0] code;
        seed = 50;
        reset_n               <= 1'b0;
        channel_enabled       <= 1'b0;
        hit                   <= 1'b0;
        external_trigger      <= 1'b0;
        cross_trigger         <= 1'b0;
        channel_mask          <= 1'b0;
        external_trigger_mask <= 1'b0;
        cross_trigger_mask    <= 1'b0;
        chip_id               <= 8'd0;
        channel_id            <= 6'd0;
        timestamp             <= 32'd0;
        adc_burst             <= 8'd0;
        adc_hold_delay        <= 8'd0;
        reset_length          <= 8'd0;
        digital_threshold     <= 8'd0;
        read_local_fifo_n     <= 1'b1;
        analog_code           <= 8'd0;
        repeat (16) step();
        reset_n <= 1'b1;
        repeat (2) step();
        check_value("fifo_empty", 64'(fifo_empty), 64'd1);
        check_value("csa_reset", 64'(csa_reset), 64'd0);
        check_value("sample", 64'(sample), 64'd1);
        check_value("dac_word", 64'(dac_word), 64'h80);
        finish_test("after reset");

        for (i = 0; i < 8; i++) begin
            adc_burst         <= 8'd0;
            adc_hold_delay    <= draw(MAX_HOLD + 1);
            reset_length      <= draw(16);
            digital_threshold <= 8'd0;
            fire(1'b1, 3'b001, 3'b000, draw(256), "natural hit");
        end

        for (i = 0; i < 12; i++) begin
            adc_burst      <= 8'd1;
            adc_hold_delay <= draw(MAX_HOLD + 1);
            reset_length   <= draw(16);
            if (i == 0)
                fire(1'b1, 3'b111, 3'b111, draw(256), "all masked");
            else if (i == 1)
                fire(1'b0, 3'b111, 3'b000, draw(256), "channel disabled");
            else
                fire(draw(4) != 8'd0, 3'(draw(8)), 3'(draw(8)), draw(256), "trigger type");
        end

        for (i = 0; i < 6; i++) begin
            thr = draw(200) + 8'd28;    // leaves room below the threshold
            case (i % 3)
                0:       code = thr;
                1:       code = thr - 8'd1 - draw(20);
                default: code = draw(256);
            endcase
            adc_burst         <= 8'd0;
            adc_hold_delay    <= draw(MAX_HOLD + 1);
            digital_threshold <= thr;
            fire(1'b1, 3'b001, 3'b000, code, "threshold");
        end

        for (i = 0; i < MAX_BURST; i++) begin
            adc_burst         <= 8'(i + 1);
            adc_hold_delay    <= draw(MAX_HOLD + 1);
            reset_length      <= (i == 0) ? 8'd0 : draw(16);
            digital_threshold <= 8'd0;
            fire(1'b1, 3'b010, 3'b000, draw(256), "burst");
        end

        ////////////////////
        // back-pressure, nine triggers into an 8-deep FIFO

        reads_held = 1'b1;
        adc_burst    <= 8'd1;
        reset_length <= 8'd0;
        for (i = 0; i < DEPTH + 1; i++) begin
            adc_hold_delay <= draw(MAX_HOLD + 1);
            fire(1'b1, 3'b001, 3'b000, draw(256), "back-pressure");
        end
        repeat (10) step();
        check_value("fifo_empty", 64'(fifo_empty), 64'd0);
        hit <= 1'b1;                    // arrives while stalled, ignored
        step();
        hit <= 1'b0;
        step();
        rd_before    = exp_rd;
        pops_granted = 1;
        while (exp_rd == rd_before)
            step();
        repeat (4) step();              // stalled event goes in behind the pop
        reads_held = 1'b0;
        repeat (3) step();
        while (exp_rd < exp_q.size())
            step();
        repeat (MAX_HOLD + 16) step();
        finish_test("back-pressure drain");

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule
